/* Bender.yml */
package:
  name: riscv_dpath

sources:
  - rtl/dpath_pkg.sv
  - rtl/operand_if.sv
  - rtl/fetch_pc_unit.sv
  - rtl/decode_operands.sv
  - rtl/reg_file.sv
  - rtl/execute_unit.sv
  - rtl/mem_wb_unit.sv
  - rtl/riscv_dpath_top.sv
  - target: simulation
    files:
      - sim/riscv_dpath_assertions.sv
      - sim/tb_riscv_dpath.sv

/* rtl/decode_operands.sv */
// Decode stage datapath
// Field and immediate extraction, operand selects and target adders

`timescale 1ns/1ps

module decode_operands import dpath_pkg::*; (
  input  word_t          inst,
  input  word_t          pc_d,
  input  word_t          pc_plus4_d,
  input  word_t          rdata0,     // rs1 value
  input  word_t          rdata1,     // rs2 value
  input  op0_sel_e       op0_sel,
  input  op1_sel_e       op1_sel,
  output reg_addr_t      raddr0,
  output reg_addr_t      raddr1,
  operand_if.decode      ops
);

  logic [4:0] shamt;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_sb;
  word_t      imm_u;
  word_t      imm_uj;

  // ----------------------------------------
  // Instruction fields
  // ----------------------------------------

  assign raddr0 = inst[19:15];  // rs1
  assign raddr1 = inst[24:20];  // rs2
  assign shamt  = inst[24:20];  // Same bits as rs2

  // Immediates, all sign extended from bit 31 except U
  assign imm_i  = {{20{inst[31]}}, inst[31:20]};
  assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_sb = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u  = {inst[31:12], 12'b0};
  assign imm_uj = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // ----------------------------------------
  // Operand selects
  // ----------------------------------------

  always_comb begin
    unique case (op0_sel)
      OP0_RDATA: ops.op0 = rdata0;
      OP0_PC:    ops.op0 = pc_d;
      OP0_PC4:   ops.op0 = pc_plus4_d;  // Link value for jal/jalr
      default:   ops.op0 = '0;
    endcase
  end

  always_comb begin
    case (op1_sel)
      OP1_RDATA:  ops.op1 = rdata1;
      OP1_SHAMT:  ops.op1 = {27'd0, shamt};
      OP1_IMM_U:  ops.op1 = imm_u;
      OP1_IMM_SB: ops.op1 = imm_sb;
      OP1_IMM_I:  ops.op1 = imm_i;
      OP1_IMM_S:  ops.op1 = imm_s;
      default:    ops.op1 = '0;  // OP1_ZERO and code 7
    endcase
  end

  assign ops.wdata = rdata1;  // Store data

  // ----------------------------------------
  // Control transfer targets
  // ----------------------------------------

  assign ops.branch_targ  = pc_d + imm_sb;
  assign ops.jump_targ    = pc_d + imm_uj;
  assign ops.jumpreg_targ = (rdata0 + imm_i) & ~word_t'(1);  // jalr clears bit 0

endmodule

/* rtl/dpath_pkg.sv */
// Datapath package for the five-stage RISC-V integer pipeline
// Widths, reset vector, mux select codes and ALU/load function codes

package dpath_pkg;

  localparam int XLEN       = 32;            // Data and address width
  localparam int REG_ADDR_W = 5;             // Register specifier width

  localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0008_0000;  // First fetch address

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // ----------------------------------------
  // Mux selects driven by the controller
  // ----------------------------------------

  typedef enum logic [1:0] {
    PC_PLUS4   = 2'd0,  // Sequential fetch
    PC_BRANCH  = 2'd1,  // Taken branch
    PC_JUMP    = 2'd2,  // jal
    PC_JUMPREG = 2'd3   // jalr
  } pc_sel_e;

  typedef enum logic [1:0] {
    OP0_RDATA = 2'd0,
    OP0_PC    = 2'd1,
    OP0_PC4   = 2'd2,
    OP0_ZERO  = 2'd3
  } op0_sel_e;

  // Code 7 is unassigned and selects zero
  typedef enum logic [2:0] {
    OP1_RDATA  = 3'd0,
    OP1_SHAMT  = 3'd1,
    OP1_IMM_U  = 3'd2,
    OP1_IMM_SB = 3'd3,
    OP1_IMM_I  = 3'd4,
    OP1_IMM_S  = 3'd5,
    OP1_ZERO   = 3'd6
  } op1_sel_e;

  // ----------------------------------------
  // Function codes
  // ----------------------------------------

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0, ALU_SUB = 4'd1, ALU_SLL = 4'd2,  ALU_OR  = 4'd3,
    ALU_LT  = 4'd4, ALU_LTU = 4'd5, ALU_AND = 4'd6,  ALU_XOR = 4'd7,
    ALU_NOR = 4'd8, ALU_SRL = 4'd9, ALU_SRA = 4'd10
  } alu_fn_e;

  typedef enum logic [2:0] {
    LD_W  = 3'd0,  // Full word
    LD_B  = 3'd1,  // Byte, sign extended
    LD_BU = 3'd2,  // Byte, zero extended
    LD_H  = 3'd3,  // Halfword, sign extended
    LD_HU = 3'd4   // Halfword, zero extended
  } load_ext_e;

  typedef enum logic {
    WB_ALU = 1'b0,
    WB_MEM = 1'b1
  } wb_sel_e;

endpackage

/* rtl/execute_unit.sv */
// Execute stage with X register, ALU and branch comparisons
// The ALU sum doubles as the data memory address

`timescale 1ns/1ps

module execute_unit import dpath_pkg::*; (
  input  logic       clk,
  input  logic       stall_x,
  operand_if.execute ops,
  input  alu_fn_e    alu_fn,
  output word_t      alu_out,
  output word_t      wdata_x,
  output word_t      branch_targ,
  output word_t      jump_targ,
  output word_t      jumpreg_targ,
  output logic       br_eq,
  output logic       br_ne,
  output logic       br_lt,
  output logic       br_ltu,
  output logic       br_ge,
  output logic       br_geu
);

  word_t      op0_x;
  word_t      op1_x;
  logic [4:0] shamt_x;

  // X register, no reset on payload
  always_ff @(posedge clk) begin
    if (!stall_x) begin
      op0_x        <= ops.op0;
      op1_x        <= ops.op1;
      wdata_x      <= ops.wdata;
      branch_targ  <= ops.branch_targ;
      jump_targ    <= ops.jump_targ;
      jumpreg_targ <= ops.jumpreg_targ;
    end
  end

  assign shamt_x = op1_x[4:0];  // Shifts use the low five bits

  // ----------------------------------------
  // ALU
  // ----------------------------------------

  always_comb begin
    case (alu_fn)
      ALU_ADD: alu_out = op0_x + op1_x;
      ALU_SUB: alu_out = op0_x - op1_x;
      ALU_SLL: alu_out = op0_x << shamt_x;
      ALU_OR:  alu_out = op0_x | op1_x;
      ALU_LT:  alu_out = word_t'(br_lt);   // slt
      ALU_LTU: alu_out = word_t'(br_ltu);  // sltu
      ALU_AND: alu_out = op0_x & op1_x;
      ALU_XOR: alu_out = op0_x ^ op1_x;
      ALU_NOR: alu_out = ~(op0_x | op1_x);
      ALU_SRL: alu_out = op0_x >> shamt_x;
      ALU_SRA: alu_out = word_t'($signed(op0_x) >>> shamt_x);
      default: alu_out = '0;  // Unused codes
    endcase
  end

  // Branch conditions for the controller
  assign br_eq  = (op0_x == op1_x);
  assign br_ne  = (op0_x != op1_x);
  assign br_lt  = ($signed(op0_x) <  $signed(op1_x));
  assign br_ltu = (op0_x < op1_x);
  assign br_ge  = ($signed(op0_x) >= $signed(op1_x));
  assign br_geu = (op0_x >= op1_x);

endmodule

/* rtl/fetch_pc_unit.sv */
// Fetch unit with PC register, startup hold and next-PC select
// Also carries the F to D pipeline register

`timescale 1ns/1ps

module fetch_pc_unit import dpath_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    stall_f,
  input  logic    stall_d,
  input  pc_sel_e pc_sel,
  input  word_t   branch_targ,   // Targets come from the X register
  input  word_t   jump_targ,
  input  word_t   jumpreg_targ,
  output word_t   imem_addr,
  output word_t   pc_d,
  output word_t   pc_plus4_d
);

  word_t pc;
  word_t pc_plus4;
  word_t pc_next;
  logic  start_hold;  // Set by reset, holds PC for one cycle

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    unique case (pc_sel)
      PC_BRANCH:  pc_next = branch_targ;
      PC_JUMP:    pc_next = jump_targ;
      PC_JUMPREG: pc_next = jumpreg_targ;
      default:    pc_next = pc_plus4;
    endcase
  end

  // Reset vector shows before the PC flop has loaded it
  assign imem_addr = reset ? RESET_VECTOR : pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= RESET_VECTOR;
      start_hold <= 1'b1;
    end else begin
      start_hold <= 1'b0;
      if (!stall_f && !start_hold) pc <= pc_next;
    end
  end

  // D register, data only
  always_ff @(posedge clk) begin
    if (!stall_d) begin
      pc_d       <= pc;
      pc_plus4_d <= pc_plus4;
    end
  end

endmodule

/* rtl/mem_wb_unit.sv */
// Memory and writeback stages
// Load extension, one-entry response hold, writeback select and W register

`timescale 1ns/1ps

module mem_wb_unit import dpath_pkg::*; (
  input  logic      clk,
  input  logic      stall_m,
  input  logic      stall_w,
  input  word_t     alu_out,     // Execute result from X
  input  load_ext_e load_ext,
  input  word_t     dmem_rdata,
  input  logic      queue_en,    // Capture the extended load word
  input  logic      queue_val,   // Use the captured word
  input  wb_sel_e   wb_sel,
  output word_t     wb_data
);

  word_t alu_m;
  word_t load_ext_m;
  word_t load_hold;
  word_t load_m;
  word_t wb_m;

  // M register
  always_ff @(posedge clk) begin
    if (!stall_m) alu_m <= alu_out;
  end

  // ----------------------------------------
  // Subword load extension
  // ----------------------------------------

  always_comb begin
    case (load_ext)
      LD_W:    load_ext_m = dmem_rdata;
      LD_B:    load_ext_m = {{24{dmem_rdata[7]}}, dmem_rdata[7:0]};
      LD_BU:   load_ext_m = {24'd0, dmem_rdata[7:0]};
      LD_H:    load_ext_m = {{16{dmem_rdata[15]}}, dmem_rdata[15:0]};
      LD_HU:   load_ext_m = {16'd0, dmem_rdata[15:0]};
      default: load_ext_m = '0;
    endcase
  end

  // Response hold for a load that arrives while M is stalled
  always_ff @(posedge clk) begin
    if (queue_en) load_hold <= load_ext_m;
  end

  assign load_m = queue_val ? load_hold : load_ext_m;

  assign wb_m = (wb_sel == WB_MEM) ? load_m : alu_m;

  // W register
  always_ff @(posedge clk) begin
    if (!stall_w) wb_data <= wb_m;
  end

endmodule

/* rtl/operand_if.sv */
// Decode to execute operand bundle
// Combinational in D, captured by the X register

`timescale 1ns/1ps

interface operand_if import dpath_pkg::*; ();

  word_t op0;           // ALU operand 0
  word_t op1;           // ALU operand 1
  word_t wdata;         // Store data, rs2 read value
  word_t branch_targ;   // pc + SB immediate
  word_t jump_targ;     // pc + UJ immediate
  word_t jumpreg_targ;  // rs1 + I immediate, bit 0 cleared

  modport decode (
    output op0, op1, wdata,
    output branch_targ, jump_targ, jumpreg_targ
  );

  modport execute (
    input op0, op1, wdata,
    input branch_targ, jump_targ, jumpreg_targ
  );

endinterface

/* rtl/reg_file.sv */
// Integer register file, two read ports and one write port
// Register 0 reads as zero and drops writes

`timescale 1ns/1ps

module reg_file import dpath_pkg::*; (
  input  logic      clk,
  input  reg_addr_t raddr0,
  input  reg_addr_t raddr1,
  input  logic      wen,
  input  reg_addr_t waddr,
  input  word_t     wdata,
  output word_t     rdata0,
  output word_t     rdata1
);

  word_t regs [2**REG_ADDR_W];

  // Combinational reads, a same-cycle write is not forwarded
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

/* rtl/riscv_dpath_top.sv */
// Five-stage RISC-V integer datapath top level
// Control comes in as selects and per-stage stall levels

`timescale 1ns/1ps

module riscv_dpath_top import dpath_pkg::*; (
  input  logic      clk,
  input  logic      reset,

  // Memory ports
  input  word_t     inst,          // Instruction in D
  input  word_t     dmem_rdata,
  output word_t     imem_addr,
  output word_t     dmem_addr,
  output word_t     dmem_wdata,

  // Controller selects
  input  pc_sel_e   pc_sel,
  input  op0_sel_e  op0_sel,
  input  op1_sel_e  op1_sel,
  input  alu_fn_e   alu_fn,
  input  load_ext_e load_ext,
  input  logic      dmem_queue_en,
  input  logic      dmem_queue_val,
  input  wb_sel_e   wb_sel,
  input  logic      rf_wen,
  input  reg_addr_t rf_waddr,

  // Stall levels
  input  logic      stall_f,
  input  logic      stall_d,
  input  logic      stall_x,
  input  logic      stall_m,
  input  logic      stall_w,

  // Status back to the controller
  output logic      br_eq,
  output logic      br_ne,
  output logic      br_lt,
  output logic      br_ltu,
  output logic      br_ge,
  output logic      br_geu,
  output word_t     proc2csr_data
);

  word_t     pc_d;
  word_t     pc_plus4_d;
  reg_addr_t raddr0;
  reg_addr_t raddr1;
  word_t     rdata0;
  word_t     rdata1;
  word_t     branch_targ;    // X-stage targets back to fetch
  word_t     jump_targ;
  word_t     jumpreg_targ;
  word_t     alu_out;
  word_t     wdata_x;
  word_t     wb_data;

  operand_if ops_if ();  // D to X operands

  fetch_pc_unit fetch_pc_unit_inst (
    .clk          (clk),
    .reset        (reset),
    .stall_f      (stall_f),
    .stall_d      (stall_d),
    .pc_sel       (pc_sel),
    .branch_targ  (branch_targ),
    .jump_targ    (jump_targ),
    .jumpreg_targ (jumpreg_targ),
    .imem_addr    (imem_addr),
    .pc_d         (pc_d),
    .pc_plus4_d   (pc_plus4_d)
  );

  decode_operands decode_operands_inst (
    .inst       (inst),
    .pc_d       (pc_d),
    .pc_plus4_d (pc_plus4_d),
    .rdata0     (rdata0),
    .rdata1     (rdata1),
    .op0_sel    (op0_sel),
    .op1_sel    (op1_sel),
    .raddr0     (raddr0),
    .raddr1     (raddr1),
    .ops        (ops_if.decode)
  );

  reg_file reg_file_inst (
    .clk    (clk),
    .raddr0 (raddr0),
    .raddr1 (raddr1),
    .wen    (rf_wen),
    .waddr  (rf_waddr),
    .wdata  (wb_data),   // Written from W
    .rdata0 (rdata0),
    .rdata1 (rdata1)
  );

  execute_unit execute_unit_inst (
    .clk          (clk),
    .stall_x      (stall_x),
    .ops          (ops_if.execute),
    .alu_fn       (alu_fn),
    .alu_out      (alu_out),
    .wdata_x      (wdata_x),
    .branch_targ  (branch_targ),
    .jump_targ    (jump_targ),
    .jumpreg_targ (jumpreg_targ),
    .br_eq        (br_eq),
    .br_ne        (br_ne),
    .br_lt        (br_lt),
    .br_ltu       (br_ltu),
    .br_ge        (br_ge),
    .br_geu       (br_geu)
  );

  mem_wb_unit mem_wb_unit_inst (
    .clk        (clk),
    .stall_m    (stall_m),
    .stall_w    (stall_w),
    .alu_out    (alu_out),
    .load_ext   (load_ext),
    .dmem_rdata (dmem_rdata),
    .queue_en   (dmem_queue_en),
    .queue_val  (dmem_queue_val),
    .wb_sel     (wb_sel),
    .wb_data    (wb_data)
  );

  // Data memory request leaves in X
  assign dmem_addr     = alu_out;
  assign dmem_wdata    = wdata_x;
  assign proc2csr_data = wb_data;

endmodule

/* sim/dpath_testdata.txt */
// ctrl_a ctrl_b inst dmem_rdata | exp imem_addr dmem_addr dmem_wdata flags proc2csr | mask
// ctrl_a nibbles: reset pc_sel op0 op1 alu_fn load_ext wb_sel {queue_en,queue_val}
// ctrl_b: wen[16] waddr[12:8] stall_fdxmw[4:0]; flags eq ne lt ltu ge geu; mask imem daddr wdata flags csr
10360000 00000 00000000 00000000 00080000 00000000 00000000 00 00000000 10
10360000 00000 00000000 00000000 00080000 00000000 00000000 00 00000000 10
00340000 00000 12300000 00000000 00080000 00000000 00000000 00 00000000 10
00340000 00000 FF800000 00000000 00080000 00000123 00000000 1C 00000000 1B
00340000 00000 00400000 00000000 00080004 FFFFFFF8 00000000 16 00000000 1B
00340000 10100 7FF00000 00000000 00080008 00000004 00000000 1C 00000123 1B
00360000 10200 00000000 00000000 0008000C 000007FF 00000000 1C FFFFFFF8 1B
00000000 10300 00208000 00000000 00080010 00000000 00000000 23 00000004 1B
00000000 10000 00208000 00000000 00080014 0000011B FFFFFFF8 16 000007FF 1F
00001000 00000 00208000 00000000 00080018 0000012B 00000000 16 00000000 1B
00003000 00010 00208000 00000000 0008001C FFFFFFFB 00000000 16 0000011B 1B
00004000 00010 00208000 00000000 0008001C 00000000 00000000 16 0000012B 1B
00005000 00000 00208000 00000000 0008001C 00000001 00000000 16 FFFFFFFB 1B
00006000 00000 00208000 00000000 00080020 00000120 00000000 16 00000000 1B
00007000 00000 00208000 00000000 00080024 FFFFFEDB 00000000 16 00000001 1B
00008000 00000 00310000 00000000 00080028 00000004 00000000 16 00000120 1B
00002000 00000 00310000 00000000 0008002C FFFFFF80 00000004 19 FFFFFEDB 1F
00009000 00000 00310000 00000000 00080030 0FFFFFFF 00000000 19 00000004 1B
0000A000 00000 00100000 00000000 00080034 FFFFFFFF 00000000 19 FFFFFF80 1B
00000000 00000 00108000 00000000 00080038 00000123 00000123 1C 0FFFFFFF 1F
00361000 00000 04000000 00000000 0008003C 00000000 00000123 23 FFFFFFFF 1F
01360000 00000 00000000 00000000 00080040 00000000 00000000 23 00000123 1B
00360010 00000 00000000 1234F687 00080078 00000000 00000000 23 00000000 1B
00360110 00000 10000000 1234F687 0008007C 00000000 00000000 00 1234F687 11
02360210 00000 00000000 1234F687 00080080 00000000 00000000 00 FFFFFF87 11
00360310 00000 00000000 1234F687 00080178 00000000 00000000 00 00000087 11
00360412 00000 10118000 1234F687 0008017C 00000000 00000000 00 FFFFF687 11
03360011 00000 00000000 AAAA5555 00080180 00000000 00000000 00 0000F687 11
00360000 00000 00000000 00000000 00000104 00000000 00000000 00 0000F687 11
00000000 00000 00208000 00000000 00000108 00000000 00000000 23 00000000 1B
00000000 00004 00108000 00000000 0000010C 0000011B 00000000 16 00000000 1B
00000000 00000 00108000 00000000 00000110 0000011B 00000000 16 00000000 1B
00360000 00000 00000000 00000000 00000114 00000246 00000000 23 0000011B 1B
00360000 00003 00000000 00000000 00000118 00000000 00000000 23 0000011B 1B
00360000 00000 00000000 00000000 0000011C 00000000 00000000 23 0000011B 1B
00360000 00000 00000000 00000000 00000120 00000000 00000000 23 00000246 1B

/* sim/riscv_dpath_assertions.sv */
// Concurrent checks on the datapath top-level ports
// Reset fetch address, fetch alignment and branch flag pairs

`timescale 1ns/1ps

module riscv_dpath_assertions import dpath_pkg::*; (
  input logic  clk,
  input logic  reset,
  input word_t imem_addr,
  input logic  br_eq,
  input logic  br_ne,
  input logic  br_lt,
  input logic  br_ltu,
  input logic  br_ge,
  input logic  br_geu
);

  // ----------------------------------------
  // Fetch
  // ----------------------------------------

  // PC flop holds the reset vector once reset has been seen at an edge
  reset_fetch: assert property (@(posedge clk) reset |=> imem_addr == RESET_VECTOR)
    else $error("imem_addr is not the reset vector after a reset cycle");

  fetch_aligned: assert property (@(posedge clk) imem_addr[1:0] == 2'b00)
    else $error("imem_addr is not word aligned");

  // ----------------------------------------
  // Branch flags come in inverse pairs
  // ----------------------------------------

  // Equal operands also satisfy both ge compares
  eq_pair: assert property (@(posedge clk) disable iff (reset)
    (br_eq != br_ne) && (!br_eq || (br_ge && br_geu)))
    else $error("br_eq and br_ne agree, or equal operands lack br_ge and br_geu");

  lt_pair: assert property (@(posedge clk) disable iff (reset)
    (br_lt != br_ge) && (!br_lt || br_ne))
    else $error("br_lt and br_ge agree, or br_lt is set with br_ne clear");

  ltu_pair: assert property (@(posedge clk) disable iff (reset)
    (br_ltu != br_geu) && (!br_ltu || br_ne))
    else $error("br_ltu and br_geu agree, or br_ltu is set with br_ne clear");

endmodule

bind riscv_dpath_top riscv_dpath_assertions riscv_dpath_assertions_inst (
  .clk       (clk),
  .reset     (reset),
  .imem_addr (imem_addr),
  .br_eq     (br_eq),
  .br_ne     (br_ne),
  .br_lt     (br_lt),
  .br_ltu    (br_ltu),
  .br_ge     (br_ge),
  .br_geu    (br_geu)
);

/* sim/tb_riscv_dpath.sv */
// Testbench for the RISC-V integer datapath
// Replays one stimulus line per cycle from a data file and checks the outputs

`timescale 1ns/1ps

module tb_riscv_dpath import dpath_pkg::*; ();

  localparam int FIELDS  = 10;  // Words per line of the data file
  localparam int MAX_VEC = 64;

  logic      clk = 1'b0;
  logic      reset;
  word_t     inst;
  word_t     dmem_rdata;
  pc_sel_e   pc_sel;
  op0_sel_e  op0_sel;
  op1_sel_e  op1_sel;
  alu_fn_e   alu_fn;
  load_ext_e load_ext;
  logic      dmem_queue_en;
  logic      dmem_queue_val;
  wb_sel_e   wb_sel;
  logic      rf_wen;
  reg_addr_t rf_waddr;
  logic      stall_f, stall_d, stall_x, stall_m, stall_w;
  word_t     imem_addr;
  word_t     dmem_addr;
  word_t     dmem_wdata;
  logic      br_eq, br_ne, br_lt, br_ltu, br_ge, br_geu;
  word_t     proc2csr_data;

  word_t vec_mem [FIELDS*MAX_VEC];  // Flat copy of the data file
  int    num_vec;
  int    errors      = 0;
  int    checks      = 0;
  int    cycle_count = 0;
  int    cycle_limit = 1000;        // Replaced once the vectors are counted

  always #50 clk = ~clk;  // 100 ns period

  riscv_dpath_top riscv_dpath_top_inst (.*);

  // ----------------------------------------
  // Vector handling
  // ----------------------------------------

  task automatic apply_vector(input int idx);
    word_t ctrl_a;
    word_t ctrl_b;
    ctrl_a = vec_mem[idx*FIELDS];
    ctrl_b = vec_mem[idx*FIELDS+1];
    reset          = ctrl_a[28];
    pc_sel         = pc_sel_e'(ctrl_a[25:24]);
    op0_sel        = op0_sel_e'(ctrl_a[21:20]);
    op1_sel        = op1_sel_e'(ctrl_a[18:16]);
    alu_fn         = alu_fn_e'(ctrl_a[15:12]);  // Applies to the op in X
    load_ext       = load_ext_e'(ctrl_a[10:8]); // Applies in M
    wb_sel         = wb_sel_e'(ctrl_a[4]);
    dmem_queue_en  = ctrl_a[1];
    dmem_queue_val = ctrl_a[0];
    rf_wen         = ctrl_b[16];                // Applies in W
    rf_waddr       = ctrl_b[12:8];
    {stall_f, stall_d, stall_x, stall_m, stall_w} = ctrl_b[4:0];
    inst           = vec_mem[idx*FIELDS+2];
    dmem_rdata     = vec_mem[idx*FIELDS+3];
  endtask

  task automatic compare_word(input string name, input word_t got, input word_t exp,
                              input int idx);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s is %h, expected %h (vector %0d)",
               $time, name, got, exp, idx);
    end
  endtask

  task automatic check_vector(input int idx);
    word_t mask;
    word_t flags;
    mask  = vec_mem[idx*FIELDS+9];
    flags = {26'd0, br_eq, br_ne, br_lt, br_ltu, br_ge, br_geu};
    if (mask[4]) compare_word("imem_addr", imem_addr, vec_mem[idx*FIELDS+4], idx);
    if (mask[3]) compare_word("dmem_addr", dmem_addr, vec_mem[idx*FIELDS+5], idx);
    if (mask[2]) compare_word("dmem_wdata", dmem_wdata, vec_mem[idx*FIELDS+6], idx);
    if (mask[1]) compare_word("branch flags", flags, vec_mem[idx*FIELDS+7], idx);
    if (mask[0]) compare_word("proc2csr_data", proc2csr_data, vec_mem[idx*FIELDS+8], idx);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    // Idle values, reset held until the first vectors take over
    reset          = 1'b1;
    inst           = '0;
    dmem_rdata     = '0;
    pc_sel         = PC_PLUS4;
    op0_sel        = OP0_ZERO;
    op1_sel        = OP1_ZERO;
    alu_fn         = ALU_ADD;
    load_ext       = LD_W;
    dmem_queue_en  = 1'b0;
    dmem_queue_val = 1'b0;
    wb_sel         = WB_ALU;
    rf_wen         = 1'b0;
    rf_waddr       = '0;
    {stall_f, stall_d, stall_x, stall_m, stall_w} = 5'b0;

    $readmemh("sim/dpath_testdata.txt", vec_mem);
    num_vec = 0;
    while (num_vec < MAX_VEC && !$isunknown(vec_mem[num_vec*FIELDS])) num_vec++;
    cycle_limit = 4*num_vec + 20;
    if (num_vec == 0) begin
      errors++;
      $display("No vectors loaded, the data file is missing or empty");
    end

    for (int i = 0; i < num_vec; i++) begin
      @(posedge clk);
      #1 apply_vector(i);   // Drive just after the edge
      #98 check_vector(i);  // Sample just before the next edge
    end

    $display("Checks: %0d, errors: %0d, vectors: %0d", checks, errors, num_vec);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, the vector replay did not finish", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

/* vlog.f */
rtl/dpath_pkg.sv
rtl/operand_if.sv
rtl/fetch_pc_unit.sv
rtl/decode_operands.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/mem_wb_unit.sv
rtl/riscv_dpath_top.sv
sim/riscv_dpath_assertions.sv
sim/tb_riscv_dpath.sv
